// ==== src/l2_cache_pkg.sv ====
`default_nettype none

package l2_cache_pkg;

	localparam int l2_ways  = 4;
	localparam int l2_sets  = 8;
	localparam int l2_tag_w = 9;
	localparam int l2_set_w = 3;
	localparam int l2_word_w = 32;
	localparam int l2_addr_w = l2_tag_w + l2_set_w;

	typedef logic [l2_word_w-1:0] l2_word_t;
	typedef logic [l2_tag_w-1:0]  l2_tag_t;
	typedef logic [l2_set_w-1:0]  l2_set_t;
	typedef logic [$clog2(l2_ways)-1:0] l2_way_t;

	// one line is one word, so the address has no offset field
	typedef struct packed {
		l2_tag_t tag;
		l2_set_t set;
	} l2_addr_fields_t;

	typedef union packed {
		logic [l2_addr_w-1:0] raw;
		l2_addr_fields_t      fields;
	} l2_addr_u;

endpackage : l2_cache_pkg

`default_nettype wire

// ==== src/l2_ctrl_pkg.sv ====
`default_nettype none

package l2_ctrl_pkg;

	// result of the tag compare for the addressed set
	typedef struct packed {
		logic                  hit;
		l2_cache_pkg::l2_way_t hit_way;
		l2_cache_pkg::l2_way_t victim_way; // way the pseudo-LRU tree points at
		logic                  victim_dirty;
		l2_cache_pkg::l2_tag_t victim_tag;
	} l2_lookup_t;

	typedef struct packed {
		logic [l2_cache_pkg::l2_ways-1:0] ld_way;
		logic                             fill_sel; // 1 takes pmem_rdata, 0 takes the requester word
		logic [l2_cache_pkg::l2_ways-1:0] ld_tag;   // also sets the valid bit
		logic [l2_cache_pkg::l2_ways-1:0] ld_dirty;
		logic                             dirty_in;
		logic                             ld_lru;
		logic                             ld_evict;
		logic                             clr_evict; // buffer has been written back
	} l2_array_ctrl_t;

	typedef enum logic {
		wb_req,
		wb_evict
	} l2_wb_sel_t;

endpackage : l2_ctrl_pkg

`default_nettype wire

// ==== src/l2_tag_array.sv ====
`default_nettype none

module l2_tag_array (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire l2_cache_pkg::l2_set_t  set,
	input  wire l2_cache_pkg::l2_tag_t  tag,
	input  wire l2_ctrl_pkg::l2_array_ctrl_t ctrl,
	output l2_ctrl_pkg::l2_lookup_t     lookup
);
	import l2_cache_pkg::*;

	l2_tag_t tags [l2_sets][l2_ways];
	logic [l2_sets-1:0][l2_ways-1:0] valid_bits;
	logic [l2_sets-1:0][l2_ways-1:0] dirty_bits;
	logic [l2_sets-1:0][2:0] lru_bits; // [2] root, [1] ways 0/1, [0] ways 2/3

	logic [l2_ways-1:0] match;
	logic [2:0] lru_cur;
	logic [2:0] lru_next;
	l2_way_t victim;
	l2_way_t acc_way;

	always_comb begin
		for (int w = 0; w < l2_ways; w++) begin
			match[w] = valid_bits[set][w] && (tags[set][w] == tag);
		end
	end

	assign lru_cur = lru_bits[set];
	// root picks the pair, the pair bit picks the way inside it
	assign victim = lru_cur[2] ? {1'b1, lru_cur[0]} : {1'b0, lru_cur[1]};

	always_comb begin
		lookup = '0;
		for (int w = 0; w < l2_ways; w++) begin
			if (match[w]) begin
				lookup.hit = 1'b1;
				lookup.hit_way = l2_way_t'(w);
			end
		end
		lookup.victim_way = victim;
		lookup.victim_dirty = dirty_bits[set][victim];
		lookup.victim_tag = tags[set][victim];
	end

	// a fill has no hit yet, so the way being filled is the victim
	assign acc_way = lookup.hit ? lookup.hit_way : victim;

	always_comb begin
		lru_next = lru_cur;
		lru_next[2] = ~acc_way[1]; // send the root to the other pair
		if (acc_way[1])
			lru_next[0] = ~acc_way[0];
		else
			lru_next[1] = ~acc_way[0];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			lru_bits <= '0;
		end else begin
			for (int w = 0; w < l2_ways; w++) begin
				if (ctrl.ld_tag[w])
					valid_bits[set][w] <= 1'b1;
				if (ctrl.ld_dirty[w])
					dirty_bits[set][w] <= ctrl.dirty_in;
			end
			if (ctrl.ld_lru)
				lru_bits[set] <= lru_next;
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < l2_ways; w++) begin
			if (ctrl.ld_tag[w])
				tags[set][w] <= tag;
		end
	end

	// two valid copies of one tag in a set would make hit_way ambiguous
	a_hit_unique : assert property (
		@(posedge clk) disable iff (!arst_n)
		lookup.hit |-> ($onehot(match) && match[lookup.hit_way])
	);

endmodule : l2_tag_array

`default_nettype wire

// ==== src/l2_data_array.sv ====
`default_nettype none

module l2_data_array (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire l2_cache_pkg::l2_set_t   set,
	input  wire l2_ctrl_pkg::l2_array_ctrl_t ctrl,
	input  wire l2_ctrl_pkg::l2_lookup_t lookup,
	input  wire l2_cache_pkg::l2_word_t  cpu_wdata,
	input  wire l2_cache_pkg::l2_word_t  pmem_rdata,
	output l2_cache_pkg::l2_word_t       rdata,
	output l2_cache_pkg::l2_word_t       evict_data,
	output l2_cache_pkg::l2_addr_u       evict_addr,
	output logic                         evict_full
);
	import l2_cache_pkg::*;

	l2_word_t lines [l2_ways][l2_sets];
	l2_word_t wr_word;

	assign wr_word = ctrl.fill_sel ? pmem_rdata : cpu_wdata;
	assign rdata = lines[lookup.hit_way][set];

	always_ff @(posedge clk) begin
		for (int w = 0; w < l2_ways; w++) begin
			if (ctrl.ld_way[w])
				lines[w][set] <= wr_word;
		end
	end

	// victim is captured before the fill overwrites its line
	always_ff @(posedge clk) begin
		if (ctrl.ld_evict) begin
			evict_data <= lines[lookup.victim_way][set];
			evict_addr.fields.tag <= lookup.victim_tag;
			evict_addr.fields.set <= set;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			evict_full <= 1'b0;
		else if (ctrl.ld_evict)
			evict_full <= 1'b1;
		else if (ctrl.clr_evict)
			evict_full <= 1'b0;
	end

	a_ld_way_onehot : assert property (
		@(posedge clk) disable iff (!arst_n)
		$onehot0(ctrl.ld_way)
	);

endmodule : l2_data_array

`default_nettype wire

// ==== src/l2_cache_control.sv ====
`default_nettype none

module l2_cache_control (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire                          mem_read,
	input  wire                          mem_write,
	input  wire                          pmem_resp,
	input  wire l2_ctrl_pkg::l2_lookup_t lookup,
	input  wire                          evict_full,
	output l2_ctrl_pkg::l2_array_ctrl_t  ctrl,
	output l2_ctrl_pkg::l2_wb_sel_t      wb_sel,
	output logic                         pmem_read,
	output logic                         pmem_write,
	output logic                         mem_resp
);
	import l2_cache_pkg::*;
	import l2_ctrl_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_fill,
		st_respond,
		st_writeback
	} state_t;

	state_t state;
	state_t next_state;

	logic [l2_ways-1:0] hit_oh;
	logic [l2_ways-1:0] victim_oh;

	assign hit_oh = l2_ways'(1) << lookup.hit_way;
	assign victim_oh = l2_ways'(1) << lookup.victim_way;

	always_comb begin
		ctrl = '0;
		wb_sel = wb_req;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		mem_resp = 1'b0;
		next_state = state;

		case (state)
			st_idle: begin
				if (mem_read || mem_write)
					next_state = st_lookup;
			end

			st_lookup: begin
				if (lookup.hit) begin
					ctrl.ld_lru = 1'b1;
					if (mem_write) begin
						ctrl.ld_way = hit_oh;
						ctrl.ld_dirty = hit_oh;
						ctrl.dirty_in = 1'b1;
						next_state = st_respond;
					end else begin
						mem_resp = 1'b1; // read data comes straight from the array
						next_state = evict_full ? st_writeback : st_idle;
					end
				end else begin
					// a clean victim is simply overwritten by the fill
					ctrl.ld_evict = lookup.victim_dirty;
					next_state = st_fill;
				end
			end

			st_fill: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					ctrl.ld_way = victim_oh;
					ctrl.fill_sel = 1'b1;
					ctrl.ld_tag = victim_oh;
					ctrl.ld_dirty = victim_oh; // dirty_in stays low, so the new line is clean
					ctrl.ld_lru = 1'b1;
					next_state = st_idle; // second pass through lookup hits
				end
			end

			st_respond: begin
				mem_resp = 1'b1;
				next_state = evict_full ? st_writeback : st_idle;
			end

			st_writeback: begin
				pmem_write = 1'b1;
				wb_sel = wb_evict;
				if (pmem_resp) begin
					ctrl.clr_evict = 1'b1;
					next_state = st_idle;
				end
			end

			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= st_idle;
		else
			state <= next_state;
	end

	a_pmem_excl : assert property (
		@(posedge clk) disable iff (!arst_n)
		!(pmem_read && pmem_write)
	);

	// the requester must not see a response before the line is in the array
	a_no_resp_in_fill : assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == st_fill) |-> !mem_resp
	);

endmodule : l2_cache_control

`default_nettype wire

// ==== src/l2_cache.sv ====
`default_nettype none

module l2_cache (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         mem_read,
	input  wire                         mem_write,
	input  wire l2_cache_pkg::l2_addr_u mem_addr,
	input  wire l2_cache_pkg::l2_word_t mem_wdata,
	output l2_cache_pkg::l2_word_t      mem_rdata,
	output logic                        mem_resp,
	output logic                        pmem_read,
	output logic                        pmem_write,
	output l2_cache_pkg::l2_addr_u      pmem_addr,
	output l2_cache_pkg::l2_word_t      pmem_wdata,
	input  wire l2_cache_pkg::l2_word_t pmem_rdata,
	input  wire                         pmem_resp
);
	import l2_cache_pkg::*;
	import l2_ctrl_pkg::*;

	l2_lookup_t lookup;
	l2_array_ctrl_t ctrl;
	l2_wb_sel_t wb_sel;
	l2_word_t evict_data;
	l2_addr_u evict_addr;
	logic evict_full;

	l2_cache_control u_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.pmem_resp  (pmem_resp),
		.lookup     (lookup),
		.evict_full (evict_full),
		.ctrl       (ctrl),
		.wb_sel     (wb_sel),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write),
		.mem_resp   (mem_resp)
	);

	l2_tag_array u_tags (
		.clk    (clk),
		.arst_n (arst_n),
		.set    (mem_addr.fields.set),
		.tag    (mem_addr.fields.tag),
		.ctrl   (ctrl),
		.lookup (lookup)
	);

	l2_data_array u_data (
		.clk        (clk),
		.arst_n     (arst_n),
		.set        (mem_addr.fields.set),
		.ctrl       (ctrl),
		.lookup     (lookup),
		.cpu_wdata  (mem_wdata),
		.pmem_rdata (pmem_rdata),
		.rdata      (mem_rdata),
		.evict_data (evict_data),
		.evict_addr (evict_addr),
		.evict_full (evict_full)
	);

	// fills read at the request address, writebacks use the buffered victim
	assign pmem_addr = (wb_sel == wb_evict) ? evict_addr : mem_addr;
	assign pmem_wdata = (wb_sel == wb_evict) ? evict_data : mem_wdata;

endmodule : l2_cache

`default_nettype wire

// ==== testbench/l2_pmem_model.sv ====
`default_nettype none

module l2_pmem_model (
	input  wire                         clk,
	input  wire                         pmem_read,
	input  wire                         pmem_write,
	input  wire l2_cache_pkg::l2_addr_u pmem_addr,
	input  wire l2_cache_pkg::l2_word_t pmem_wdata,
	output l2_cache_pkg::l2_word_t      pmem_rdata,
	output logic                        pmem_resp
);
	import l2_cache_pkg::*;

	l2_word_t mem [1 << l2_addr_w];
	integer seed;
	int left;
	int writes;
	logic busy;

	initial begin
		seed = 91;
		left = 0;
		writes = 0;
		busy = 1'b0;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		for (int a = 0; a < (1 << l2_addr_w); a++)
			mem[a] = {16'hc0de, 16'(a)}; // upper half is a marker, lower half the address
	end

	// a request is seen on a falling edge and answered 1 to 6 cycles later
	always @(negedge clk) begin
		if (pmem_resp) begin
			pmem_resp <= 1'b0;
			busy = 1'b0;
		end else if (pmem_read || pmem_write) begin
			if (!busy) begin
				busy = 1'b1;
				left = 1 + int'($unsigned($random(seed)) % 6);
			end
			left = left - 1;
			if (left == 0) begin
				if (pmem_write) begin
					mem[pmem_addr.raw] = pmem_wdata;
					writes++;
					$display("pmem write %0d: [%h] <= %h", writes, pmem_addr.raw, pmem_wdata);
				end else begin
					pmem_rdata <= mem[pmem_addr.raw];
				end
				pmem_resp <= 1'b1;
			end
		end
	end

endmodule : l2_pmem_model

`default_nettype wire

// ==== testbench/l2_cache_tb.sv ====
`default_nettype none

module l2_cache_tb;
	import l2_cache_pkg::*;

	localparam int timeout_cycles = 200;
	localparam int stim_words = 4 * 32;

	logic clk;
	logic arst_n;
	logic mem_read;
	logic mem_write;
	l2_addr_u mem_addr;
	l2_word_t mem_wdata;
	l2_word_t mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	l2_addr_u pmem_addr;
	l2_word_t pmem_wdata;
	l2_word_t pmem_rdata;
	logic pmem_resp;

	logic [31:0] stim [stim_words];
	l2_word_t shadow [1 << l2_addr_w];
	logic written [1 << l2_addr_w];
	l2_addr_u done_addr;
	l2_addr_u wb_exp;
	int checks, errors, test_checks, test_errors, tests, wb_count;
	logic aborted;
	logic wb_busy;

	l2_cache dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_resp   (mem_resp),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write),
		.pmem_addr  (pmem_addr),
		.pmem_wdata (pmem_wdata),
		.pmem_rdata (pmem_rdata),
		.pmem_resp  (pmem_resp)
	);

	l2_pmem_model pmem0 (
		.clk        (clk),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write),
		.pmem_addr  (pmem_addr),
		.pmem_wdata (pmem_wdata),
		.pmem_rdata (pmem_rdata),
		.pmem_resp  (pmem_resp)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic note_result(input logic ok);
		checks++;
		test_checks++;
		if (!ok) begin
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_word(input string name, input l2_word_t got, input l2_word_t exp);
		note_result(got === exp);
		if (got !== exp)
			$display("ERR %s: got %h, expected %h", name, got, exp);
	endtask

	task automatic check_addr(input string name, input l2_addr_u got, input l2_addr_u exp);
		note_result(got.raw === exp.raw);
		if (got.raw !== exp.raw)
			$display("ERR %s: got %h, expected %h", name, got.raw, exp.raw);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		note_result(got === exp);
		if (got !== exp)
			$display("ERR %s: got %h, expected %h", name, got, exp);
	endtask

	task automatic close_test(input int num);
		if (num == 4) begin
			note_result(wb_count > 0);
			if (wb_count == 0)
				$display("the eviction test never wrote a line back to memory");
		end
		tests++;
		$display("test %0d done: %0d checks, %0d errors", num, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// op low nibble is 0 for read, 1 for write, 2 for read hit and 3 for write hit
	task automatic run_request(input logic [7:0] op, input l2_addr_u addr,
			input l2_word_t wdata, input l2_word_t exp_rdata);
		int kind;
		int edges;
		logic saw_pmem_read;
		logic got_resp;
		l2_word_t rdata;
		kind = op[3:0];
		edges = 0;
		saw_pmem_read = 1'b0;
		got_resp = 1'b0;
		rdata = '0;
		mem_read = !op[0];
		mem_write = op[0];
		mem_addr = addr;
		mem_wdata = wdata;
		// a mem_resp seen between edges is taken by the requester at the next rising edge
		while (!got_resp && edges < timeout_cycles) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			saw_pmem_read |= pmem_read;
			if (mem_resp) begin
				got_resp = 1'b1;
				rdata = mem_rdata;
				done_addr = addr;
			end
		end
		if (got_resp) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		mem_read = 1'b0;
		mem_write = 1'b0;
		note_result(got_resp);
		if (!got_resp) begin
			$display("no response from the cache to the request at %h", addr.raw);
			aborted = 1'b1;
		end else begin
			if (op[0]) begin
				shadow[addr.raw] = wdata;
				written[addr.raw] = 1'b1;
			end else begin
				check_word("mem_rdata", rdata, exp_rdata);
			end
			if (kind >= 2) begin // a hit kind equals the edge its response is due on
				note_result(edges == kind);
				if (edges != kind)
					$display("response to %h came at edge %0d, not %0d", addr.raw, edges, kind);
			end
			if (kind == 2)
				check_bit("pmem_read", saw_pmem_read, 1'b0);
		end
	endtask

	// the victim always comes from the set of the request that just finished
	always @(negedge clk) begin
		if (!arst_n || !pmem_write) begin
			wb_busy = 1'b0;
		end else if (!wb_busy) begin
			wb_busy = 1'b1;
			wb_count++;
			note_result(written[pmem_addr.raw] === 1'b1);
			if (written[pmem_addr.raw] !== 1'b1)
				$display("write back to %h, which holds no new requester write", pmem_addr.raw);
			else
				check_word("pmem_wdata", pmem_wdata, shadow[pmem_addr.raw]);
			written[pmem_addr.raw] = 1'b0; // the line has left the cache
			wb_exp = done_addr;
			wb_exp.fields.tag = pmem_addr.fields.tag;
			check_addr("pmem_addr", pmem_addr, wb_exp);
		end
	end

	initial begin
		int idx;
		int cur_test;
		int n;
		logic [7:0] op;
		checks = 0;
		errors = 0;
		test_checks = 0;
		test_errors = 0;
		tests = 0;
		wb_count = 0;
		aborted = 1'b0;
		wb_busy = 1'b0;
		done_addr = '0;
		arst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		for (int a = 0; a < (1 << l2_addr_w); a++) begin
			shadow[a] = '0;
			written[a] = 1'b0;
		end
		$readmemh("testbench/l2_stim.txt", stim);
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		repeat (5) begin
			@(posedge clk);
			check_bit("mem_resp", mem_resp, 1'b0);
			check_bit("pmem_read", pmem_read, 1'b0);
			check_bit("pmem_write", pmem_write, 1'b0);
		end
		@(negedge clk);
		close_test(1);

		cur_test = 2;
		idx = 0;
		op = stim[0][7:0];
		while (!aborted && op != 8'hff && idx + 4 <= stim_words) begin
			if (op[7:4] != cur_test) begin
				close_test(cur_test);
				cur_test = op[7:4];
			end
			run_request(op, stim[idx+1][l2_addr_w-1:0], stim[idx+2], stim[idx+3]);
			idx += 4;
			op = (idx < stim_words) ? stim[idx][7:0] : 8'hff;
		end

		// let a trailing write back finish before the last test closes
		n = 0;
		while ((pmem_read || pmem_write) && n < timeout_cycles) begin
			@(negedge clk);
			n++;
		end
		note_result(n < timeout_cycles);
		if (n >= timeout_cycles)
			$display("memory traffic did not finish within %0d cycles", timeout_cycles);
		close_test(cur_test);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule : l2_cache_tb

`default_nettype wire

// ==== testbench/l2_stim.txt ====
// op (high nibble test, low nibble 0 read 1 write 2 read hit 3 write hit)
// address, write data, expected read data
20 123 00000000 c0de0123
22 123 00000000 c0de0123
33 123 11110001 00000000
32 123 00000000 11110001
31 0a5 22220002 00000000
32 0a5 00000000 22220002
41 00e 4000000e 00000000
41 016 40000016 00000000
41 01e 4000001e 00000000
41 026 40000026 00000000
41 02e 4000002e 00000000
40 00e 00000000 4000000e
40 016 00000000 40000016
40 01e 00000000 4000001e
40 026 00000000 40000026
40 02e 00000000 4000002e
51 300 55550300 00000000
51 3f8 555503f8 00000000
50 123 00000000 11110001
50 7ff 00000000 c0de07ff
51 7ff 77770000 00000000
50 036 00000000 c0de0036
50 046 00000000 c0de0046
50 00e 00000000 4000000e
50 300 00000000 55550300
50 7ff 00000000 77770000
50 fff 00000000 c0de0fff
ff 000 00000000 00000000

// ==== tb.f ====
src/l2_cache_pkg.sv
src/l2_ctrl_pkg.sv
src/l2_tag_array.sv
src/l2_data_array.sv
src/l2_cache_control.sv
src/l2_cache.sv
testbench/l2_pmem_model.sv
testbench/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - files:
      - src/l2_cache_pkg.sv
      - src/l2_ctrl_pkg.sv
      - src/l2_tag_array.sv
      - src/l2_data_array.sv
      - src/l2_cache_control.sv
      - src/l2_cache.sv
  - target: test
    files:
      - testbench/l2_pmem_model.sv
      - testbench/l2_cache_tb.sv
